// ==== hdl/sb_egress_pkg.sv ====
package sb_egress_pkg;

    // ----------------------------------------------------------
    // Payload
    // ----------------------------------------------------------

    // Internal payload bits carried by one transfer
    localparam int pld_width = 8;

    // Payload bytes that make up one dword
    localparam int bytes_per_dword = 4;

    // Byte position within the current dword, 0 to 3
    localparam int cnt_width = 2;

    // ----------------------------------------------------------
    // Egress FIFO
    // ----------------------------------------------------------

    // Entries held by each class queue
    // Depth is a power of two so the pointers wrap on their own
    localparam int fifo_depth = 8;

    // Read and write pointer width
    localparam int fifo_ptr_width = 3;

endpackage

// ==== hdl/flit_q_if.sv ====
`timescale 1ns/1ns

interface flit_q_if;

    // Enqueue side, written by the master mux
    logic                                push;
    logic [sb_egress_pkg::pld_width-1:0] data;
    logic                                eom;
    logic                                full;

    // Dequeue side, head of queue seen by the arbiter
    logic                                valid;
    logic [sb_egress_pkg::pld_width-1:0] head_data;
    logic                                head_eom;
    logic                                pop;

    // Mux pushes a byte and its eom, only while full is low
    modport enq (output push, output data, output eom, input full);

    // Queue itself, sees both sides and reports its state
    modport fifo (
        input  push, input  data, input  eom, input  pop,
        output full, output valid, output head_data, output head_eom
    );

    // Arbiter pops the head, only while valid is high
    modport deq (input valid, input head_data, input head_eom, output pop);

endinterface

// ==== hdl/sb_byte_count.sv ====
`timescale 1ns/1ns

module sb_byte_count
(
    input  logic agent_clk,
    input  logic agent_rst_b,
    input  logic valid,
    output logic last
);

    // Position of the next byte within the current dword
    logic [sb_egress_pkg::cnt_width-1:0] cnt;

    // ----------------------------------------------------------
    // Byte counter
    // ----------------------------------------------------------

    // Advances once per accepted byte
    // Wraps back to 0 after the fourth byte of a dword
    always_ff @(posedge agent_clk or negedge agent_rst_b)
    begin
        if (!agent_rst_b)
        begin
            cnt <= '0;
        end
        else if (valid)
        begin
            cnt <= cnt + 1'b1;
        end
    end

    // High while the byte on the bus closes the dword
    always_comb
    begin
        last = (cnt == (sb_egress_pkg::cnt_width)'(sb_egress_pkg::bytes_per_dword - 1));
    end

endmodule

// ==== hdl/sb_master_mux.sv ====
`timescale 1ns/1ns

module sb_master_mux
(
    input  logic                                agent_clk,
    input  logic                                agent_rst_b,
    input  logic                                pc_irdy,
    input  logic                                pc_eom,
    input  logic [sb_egress_pkg::pld_width-1:0] pc_data,
    input  logic                                np_irdy,
    input  logic                                np_eom,
    input  logic [sb_egress_pkg::pld_width-1:0] np_data,
    output logic                                pc_trdy,
    output logic                                np_trdy,
    output logic                                pc_msgip,
    output logic                                np_msgip,
    flit_q_if.enq                               pc_q,
    flit_q_if.enq                               np_q
);

    // Byte accepted on this edge, per class
    logic pc_put;
    logic np_put;

    // Accepted byte is the fourth of its dword
    logic pc_last;
    logic np_last;

    // ----------------------------------------------------------
    // Accept logic
    // ----------------------------------------------------------

    always_comb
    begin
        // Ready as soon as the agent asks and the queue has room
        pc_trdy = pc_irdy & ~pc_q.full;
        np_trdy = np_irdy & ~np_q.full;

        // A transfer completes when both sides of the handshake agree
        pc_put = pc_irdy & pc_trdy;
        np_put = np_irdy & np_trdy;

        // Accepted bytes go straight into the class queue
        pc_q.push = pc_put;
        pc_q.data = pc_data;
        pc_q.eom  = pc_eom;
        np_q.push = np_put;
        np_q.data = np_data;
        np_q.eom  = np_eom;
    end

    // Dword position, one counter per class
    sb_byte_count pc_cnt_i
    (
        .agent_clk   (agent_clk),
        .agent_rst_b (agent_rst_b),
        .valid       (pc_put),
        .last        (pc_last)
    );

    sb_byte_count np_cnt_i
    (
        .agent_clk   (agent_clk),
        .agent_rst_b (agent_rst_b),
        .valid       (np_put),
        .last        (np_last)
    );

    // ----------------------------------------------------------
    // Message in progress
    // ----------------------------------------------------------

    // Only a completed dword moves the flag
    // Set while more dwords follow, cleared by the one with eom
    always_ff @(posedge agent_clk or negedge agent_rst_b)
    begin
        if (!agent_rst_b)
        begin
            pc_msgip <= 1'b0;
            np_msgip <= 1'b0;
        end
        else
        begin
            if (pc_put && pc_last)
            begin
                pc_msgip <= ~pc_eom;
            end
            if (np_put && np_last)
            begin
                np_msgip <= ~np_eom;
            end
        end
    end

endmodule

// ==== hdl/sb_egress_fifo.sv ====
`timescale 1ns/1ns

module sb_egress_fifo
(
    input  logic  agent_clk,
    input  logic  agent_rst_b,
    flit_q_if.fifo q
);

    // Storage, one payload byte and its eom bit per entry
    logic [sb_egress_pkg::pld_width-1:0] mem_data [sb_egress_pkg::fifo_depth];
    logic                                mem_eom  [sb_egress_pkg::fifo_depth];

    logic [sb_egress_pkg::fifo_ptr_width-1:0] wr_ptr;
    logic [sb_egress_pkg::fifo_ptr_width-1:0] rd_ptr;

    // One bit wider than the pointers so a full queue is told from an empty one
    logic [sb_egress_pkg::fifo_ptr_width:0] count;

    logic do_push;
    logic do_pop;

    // ----------------------------------------------------------
    // Status and head
    // ----------------------------------------------------------

    always_comb
    begin
        // Status compares the registered occupancy
        q.full  = (count == (sb_egress_pkg::fifo_ptr_width + 1)'(sb_egress_pkg::fifo_depth));
        q.valid = (count != '0);

        // Head comes from the entry under the read pointer
        q.head_data = mem_data[rd_ptr];
        q.head_eom  = mem_eom[rd_ptr];

        do_push = q.push & ~q.full;
        do_pop  = q.pop & q.valid;
    end

    // ----------------------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------------------

    always_ff @(posedge agent_clk or negedge agent_rst_b)
    begin
        if (!agent_rst_b)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            if (do_push && !do_pop)
            begin
                count <= count + 1'b1;
            end
            else if (do_pop && !do_push)
            begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage write
    always_ff @(posedge agent_clk)
    begin
        if (do_push)
        begin
            mem_data[wr_ptr] <= q.data;
            mem_eom[wr_ptr]  <= q.eom;
        end
    end

endmodule

// ==== hdl/sb_egress_arb.sv ====
`timescale 1ns/1ns

module sb_egress_arb
(
    input  logic                                agent_clk,
    input  logic                                agent_rst_b,
    flit_q_if.deq                               pc_q,
    flit_q_if.deq                               np_q,
    input  logic                                out_ready,
    output logic                                out_valid,
    output logic [sb_egress_pkg::pld_width-1:0] out_data,
    output logic                                out_eom,
    output logic                                out_np
);

    // Grant is held for the rest of the current message
    logic locked;
    // Class held while locked, 1 for np
    logic lock_np;
    // Round-robin pointer, 1 when np wins the next tie
    logic prio_np;

    // Class selected this cycle
    logic sel_np;

    // Selected class has a byte to offer
    logic pc_gnt;
    logic np_gnt;

    // ----------------------------------------------------------
    // Selection
    // ----------------------------------------------------------

    always_comb
    begin
        // Locked grant wins over anything else
        if (locked)
        begin
            sel_np = lock_np;
        end
        // Tie goes to the class not served last
        else if (pc_q.valid && np_q.valid)
        begin
            sel_np = prio_np;
        end
        else
        begin
            sel_np = np_q.valid;
        end

        pc_gnt = ~sel_np & pc_q.valid;
        np_gnt =  sel_np & np_q.valid;
    end

    // ----------------------------------------------------------
    // Egress port
    // ----------------------------------------------------------

    always_comb
    begin
        // Port follows the granted head in the same cycle
        out_valid = pc_gnt | np_gnt;
        out_data  = sel_np ? np_q.head_data : pc_q.head_data;
        out_eom   = sel_np ? np_q.head_eom : pc_q.head_eom;
        out_np    = sel_np;

        // Pop the granted head on every accepted transfer
        pc_q.pop = pc_gnt & out_ready;
        np_q.pop = np_gnt & out_ready;
    end

    // ----------------------------------------------------------
    // Grant lock and round robin
    // ----------------------------------------------------------

    // A byte on offer that is not taken also locks the grant
    // so the port holds steady while out_ready is low
    always_ff @(posedge agent_clk or negedge agent_rst_b)
    begin
        if (!agent_rst_b)
        begin
            locked  <= 1'b0;
            lock_np <= 1'b0;
            prio_np <= 1'b0;
        end
        else if (out_valid)
        begin
            if (out_ready && out_eom)
            begin
                // End of message, hand priority to the other class
                locked  <= 1'b0;
                prio_np <= ~sel_np;
            end
            else
            begin
                locked  <= 1'b1;
                lock_np <= sel_np;
            end
        end
    end

endmodule

// ==== hdl/sb_egress_top.sv ====
`timescale 1ns/1ns

module sb_egress_top
(
    input  logic                                agent_clk,
    input  logic                                agent_rst_b,
    input  logic                                pc_irdy,
    input  logic                                pc_eom,
    input  logic [sb_egress_pkg::pld_width-1:0] pc_data,
    input  logic                                np_irdy,
    input  logic                                np_eom,
    input  logic [sb_egress_pkg::pld_width-1:0] np_data,
    input  logic                                out_ready,
    output logic                                pc_trdy,
    output logic                                np_trdy,
    output logic                                pc_msgip,
    output logic                                np_msgip,
    output logic                                out_valid,
    output logic [sb_egress_pkg::pld_width-1:0] out_data,
    output logic                                out_eom,
    output logic                                out_np
);

    // ----------------------------------------------------------
    // Class queues
    // ----------------------------------------------------------

    // Posted
    flit_q_if pc_q ();
    // Non-posted
    flit_q_if np_q ();

    // ----------------------------------------------------------
    // Ingress side
    // ----------------------------------------------------------

    sb_master_mux sb_master_mux_i
    (
        .agent_clk   (agent_clk),
        .agent_rst_b (agent_rst_b),
        .pc_irdy     (pc_irdy),
        .pc_eom      (pc_eom),
        .pc_data     (pc_data),
        .np_irdy     (np_irdy),
        .np_eom      (np_eom),
        .np_data     (np_data),
        .pc_trdy     (pc_trdy),
        .np_trdy     (np_trdy),
        .pc_msgip    (pc_msgip),
        .np_msgip    (np_msgip),
        .pc_q        (pc_q.enq),
        .np_q        (np_q.enq)
    );

    // Storage, one FIFO per class
    sb_egress_fifo pc_fifo
    (
        .agent_clk   (agent_clk),
        .agent_rst_b (agent_rst_b),
        .q           (pc_q.fifo)
    );

    sb_egress_fifo np_fifo
    (
        .agent_clk   (agent_clk),
        .agent_rst_b (agent_rst_b),
        .q           (np_q.fifo)
    );

    // ----------------------------------------------------------
    // Egress side
    // ----------------------------------------------------------

    sb_egress_arb sb_egress_arb_i
    (
        .agent_clk   (agent_clk),
        .agent_rst_b (agent_rst_b),
        .pc_q        (pc_q.deq),
        .np_q        (np_q.deq),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_eom     (out_eom),
        .out_np      (out_np)
    );

endmodule

// ==== testbench/sb_egress_checker.sv ====
`timescale 1ns/1ns

module sb_egress_checker
(
    input logic                                agent_clk,
    input logic                                agent_rst_b,
    // Ingress side, bit 0 for pc and bit 1 for np
    input logic [1:0]                          push,
    input logic [1:0]                          eom,
    input logic [1:0]                          last,
    input logic [1:0]                          full,
    // Egress port
    input logic                                out_valid,
    input logic                                out_ready,
    input logic [sb_egress_pkg::pld_width-1:0] out_data,
    input logic                                out_eom,
    input logic                                out_np
);

    // ----------------------------------------------------------
    // Ingress rules
    // ----------------------------------------------------------

    // A message only closes on the fourth byte of a dword
    eom_on_last: assert property (@(posedge agent_clk) disable iff (!agent_rst_b)
        (push & eom & ~last) == 2'b00)
    else $error("eom accepted away from a dword boundary");

    // Queue never takes a byte while it is full
    no_push_full: assert property (@(posedge agent_clk) disable iff (!agent_rst_b)
        (push & full) == 2'b00)
    else $error("push into a full class queue");

    // ----------------------------------------------------------
    // Egress rules
    // ----------------------------------------------------------

    // Offered byte waits unchanged until it is taken
    hold_offer: assert property (@(posedge agent_clk) disable iff (!agent_rst_b)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_eom)
            && $stable(out_np))
    else $error("egress byte changed under back-pressure");

    // Class stays granted until its eom byte leaves
    grant_held: assert property (@(posedge agent_clk) disable iff (!agent_rst_b)
        out_valid && !(out_ready && out_eom) |=> out_np == $past(out_np))
    else $error("grant moved in the middle of a message");

endmodule

// Mux side watches both class queues
bind sb_master_mux sb_egress_checker mux_chk_i
(
    .agent_clk   (agent_clk),
    .agent_rst_b (agent_rst_b),
    .push        ({np_q.push, pc_q.push}),
    .eom         ({np_eom, pc_eom}),
    .last        ({np_last, pc_last}),
    .full        ({np_q.full, pc_q.full}),
    .out_valid   (1'b0),
    .out_ready   (1'b0),
    .out_data    ('0),
    .out_eom     (1'b0),
    .out_np      (1'b0)
);

// Arbiter side watches the shared egress port
bind sb_egress_arb sb_egress_checker arb_chk_i
(
    .agent_clk   (agent_clk),
    .agent_rst_b (agent_rst_b),
    .push        (2'b00),
    .eom         (2'b00),
    .last        (2'b00),
    .full        (2'b00),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_data    (out_data),
    .out_eom     (out_eom),
    .out_np      (out_np)
);

// ==== testbench/sb_egress_tb.sv ====
`timescale 1ns/1ns

module sb_egress_tb;

    // Run length in messages
    // Each message is at most 3 dwords
    localparam int n_single       = 8;
    localparam int n_mixed        = 24;
    localparam int max_bytes      = (2 * n_single + n_mixed + 3) * 3
                                    * sb_egress_pkg::bytes_per_dword;
    localparam int timeout_cycles = 4 * max_bytes + 200;

    logic                                agent_clk;
    logic                                agent_rst_b;
    logic                                pc_irdy;
    logic                                pc_eom;
    logic [sb_egress_pkg::pld_width-1:0] pc_data;
    logic                                np_irdy;
    logic                                np_eom;
    logic [sb_egress_pkg::pld_width-1:0] np_data;
    logic                                out_ready;
    logic                                pc_trdy;
    logic                                np_trdy;
    logic                                pc_msgip;
    logic                                np_msgip;
    logic                                out_valid;
    logic [sb_egress_pkg::pld_width-1:0] out_data;
    logic                                out_eom;
    logic                                out_np;

    // Model queues of {eom, data} entries
    logic [8:0]  pc_tx[$];
    logic [8:0]  np_tx[$];
    logic [8:0]  pc_exp[$];
    logic [8:0]  np_exp[$];
    // Class of each finished message in egress order (1 for np)
    bit          eom_log[$];
    // Byte on offer per class and bytes accepted so far
    bit          held [2];
    int          acc_cnt [2];
    // Mode of out_ready
    // 0 keeps it high and 1 draws it at random
    // 2 holds it low
    int          ready_mode;
    logic [31:0] rng_state;
    int          checks;
    int          errors;
    int          tests;
    int          cycles;

    sb_egress_top sb_egress_top_i (.*);

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAIL %0t: %s expected %0h got %0h", $time, what, expected, actual);
        end
    endtask

    // Random payload with eom on the final byte only
    task automatic queue_message(input bit np, input int dwords);
        logic [31:0] r;
        int          n;
        n = dwords * sb_egress_pkg::bytes_per_dword;
        for (int i = 0; i < n; i++)
        begin
            r = next_random();
            if (np)
            begin
                np_tx.push_back({i == n - 1, r[7:0]});
            end
            else
            begin
                pc_tx.push_back({i == n - 1, r[7:0]});
            end
        end
    endtask

    task automatic drive_agent(input bit np, input logic irdy, input logic [8:0] b);
        if (np)
        begin
            np_irdy = irdy;
            np_eom  = b[8];
            np_data = b[7:0];
        end
        else
        begin
            pc_irdy = irdy;
            pc_eom  = b[8];
            pc_data = b[7:0];
        end
    endtask

    // Agent for one class that also models its msgip flag
    task automatic drive_class(input bit np);
        logic [8:0] b;
        logic       msgip_exp;
        int         pos;
        b         = '0;
        msgip_exp = 1'b0;
        pos       = 0;
        held[np]  = 1'b0;
        drive_agent(np, 1'b0, b);
        wait (agent_rst_b === 1'b1);
        forever
        begin
            @(posedge agent_clk);
            #10;
            // A byte stays on offer until it is taken
            if (!held[np])
            begin
                b = '0;
                if ((np ? np_tx.size() : pc_tx.size()) != 0 && next_random() % 4 != 0)
                begin
                    b        = np ? np_tx[0] : pc_tx[0];
                    held[np] = 1'b1;
                end
                drive_agent(np, held[np], b);
            end
            @(negedge agent_clk);
            check_value(32'(np ? np_msgip : pc_msgip), 32'(msgip_exp),
                        np ? "np_msgip" : "pc_msgip");
            // trdy high here means the byte moves on the coming edge
            if (held[np] && (np ? np_trdy : pc_trdy))
            begin
                if (np)
                begin
                    np_exp.push_back(np_tx.pop_front());
                end
                else
                begin
                    pc_exp.push_back(pc_tx.pop_front());
                end
                acc_cnt[np]++;
                // Closing byte of a dword sets or clears the flag
                if (pos == sb_egress_pkg::bytes_per_dword - 1)
                begin
                    msgip_exp = ~b[8];
                end
                pos      = (pos + 1) % sb_egress_pkg::bytes_per_dword;
                held[np] = 1'b0;
            end
        end
    endtask

    task automatic wait_idle();
        while (pc_tx.size() != 0 || np_tx.size() != 0 || pc_exp.size() != 0
               || np_exp.size() != 0 || held[0] || held[1])
        begin
            @(negedge agent_clk);
            #1;
        end
    endtask

    task automatic wait_count(input bit np, input int target);
        while (acc_cnt[np] < target)
        begin
            @(negedge agent_clk);
            #1;
        end
    endtask

    task automatic report_test(input string name, input int start);
        tests++;
        $display("%s finished, %0d new errors", name, errors - start);
    endtask

    // ----------------------------------------------------------
    // Clock, out_ready, timeout and egress monitor
    // ----------------------------------------------------------

    initial
    begin
        agent_clk = 1'b0;
        forever
        begin
            #50 agent_clk = ~agent_clk;
        end
    end

    always @(posedge agent_clk)
    begin
        #10;
        if (ready_mode == 0)
        begin
            out_ready = 1'b1;
        end
        else if (ready_mode == 1)
        begin
            out_ready = (next_random() % 4) != 0;
        end
        else
        begin
            out_ready = 1'b0;
        end
    end

    initial
    begin
        cycles = 0;
        while (cycles < timeout_cycles)
        begin
            @(posedge agent_clk);
            cycles++;
        end
        $display("Run timed out after %0d cycles", cycles);
        $display("TEST FAIL");
        $finish;
    end

    // Every taken byte must be the head of its class queue
    initial
    begin
        logic [8:0] want;
        bit         in_msg;
        bit         cur_np;
        in_msg = 1'b0;
        cur_np = 1'b0;
        forever
        begin
            @(negedge agent_clk);
            if (agent_rst_b && out_valid && out_ready)
            begin
                if (in_msg)
                begin
                    check_value(32'(out_np), 32'(cur_np), "out_np inside a message");
                end
                cur_np = out_np;
                in_msg = !out_eom;
                if ((out_np ? np_exp.size() : pc_exp.size()) == 0)
                begin
                    errors++;
                    $display("Egress byte at %0t with nothing expected for its class", $time);
                end
                else
                begin
                    want = out_np ? np_exp.pop_front() : pc_exp.pop_front();
                    check_value(32'(out_data), 32'(want[7:0]), "out_data");
                    check_value(32'(out_eom), 32'(want[8]), "out_eom");
                    if (out_eom)
                    begin
                        eom_log.push_back(out_np);
                    end
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Tests
    // ----------------------------------------------------------

    initial
    begin
        logic [31:0] r;
        int          start;
        int          base;
        int          base_np;
        agent_rst_b = 1'b0;
        out_ready   = 1'b0;
        ready_mode  = 2;
        rng_state   = 32'd70402;
        checks      = 0;
        errors      = 0;
        tests       = 0;
        fork
            drive_class(1'b0);
            drive_class(1'b1);
        join_none
        repeat (2) @(posedge agent_clk);
        #10;
        agent_rst_b = 1'b1;

        // Single-class order with pc first and np second
        start      = errors;
        ready_mode = 0;
        for (int i = 0; i < n_single; i++)
        begin
            queue_message(1'b0, 1 + int'(next_random() % 3));
        end
        wait_idle();
        for (int i = 0; i < n_single; i++)
        begin
            queue_message(1'b1, 1 + int'(next_random() % 3));
        end
        wait_idle();
        report_test("Single-class order", start);

        // Mixed classes with random out_ready
        start      = errors;
        ready_mode = 1;
        for (int i = 0; i < n_mixed; i++)
        begin
            r = next_random();
            queue_message(r[0], 1 + int'(r[15:8]) % 3);
        end
        wait_idle();
        report_test("Message atomicity", start);

        // Fill both queues with pc first and then open the port
        start      = errors;
        ready_mode = 2;
        eom_log.delete();
        base    = acc_cnt[0];
        base_np = acc_cnt[1];
        for (int i = 0; i < 3; i++)
        begin
            queue_message(1'b0, 1);
        end
        wait_count(1'b0, base + 1);
        for (int i = 0; i < 3; i++)
        begin
            queue_message(1'b1, 1);
        end
        wait_count(1'b0, base + sb_egress_pkg::fifo_depth);
        wait_count(1'b1, base_np + sb_egress_pkg::fifo_depth);
        ready_mode = 0;
        wait_idle();
        check_value(32'(eom_log.size()), 32'd6, "messages in alternation");
        for (int k = 0; k < eom_log.size(); k++)
        begin
            check_value(32'(eom_log[k]), 32'(k % 2), "class order");
        end
        report_test("Round-robin alternation", start);

        // Back-pressure on pc alone
        start      = errors;
        ready_mode = 2;
        base       = acc_cnt[0];
        queue_message(1'b0, 3);
        wait_count(1'b0, base + sb_egress_pkg::fifo_depth);
        // Next byte goes on offer against the full queue
        while (!held[0] && acc_cnt[0] == base + sb_egress_pkg::fifo_depth)
        begin
            @(negedge agent_clk);
            #1;
        end
        check_value(32'(acc_cnt[0] - base), 32'(sb_egress_pkg::fifo_depth), "bytes accepted");
        check_value(32'(pc_trdy), 32'd0, "pc_trdy with a full queue");
        ready_mode = 0;
        wait_idle();
        report_test("Back-pressure", start);

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== sb_egress.f ====
hdl/sb_egress_pkg.sv
hdl/flit_q_if.sv
hdl/sb_byte_count.sv
hdl/sb_master_mux.sv
hdl/sb_egress_fifo.sv
hdl/sb_egress_arb.sv
hdl/sb_egress_top.sv
testbench/sb_egress_checker.sv
testbench/sb_egress_tb.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := sb_egress_tb
FILELIST  := sb_egress.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(wildcard hdl/*.sv testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the simulation prints the pass line
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
